/* common/rcfg_pkg.sv */
/*
 shared definitions for the reconfiguration access block
 management address, data and request struct
 channel number type and the LT/AN register offset
 state encoding of the user access FSM
*/
package rcfg_pkg;

   // management address is channel number above a 6 bit register offset
   typedef logic [9:0] mgmt_addr_t;

   typedef logic [31:0] mgmt_data_t;      // write data on the management port

   // channel number, which caps the design at 16 channels
   typedef logic [3:0] chan_idx_t;

   // register that the PHY master writes for every LT/AN service
   localparam logic [5:0] LT_AN_REG = 6'h2a;

   // one management request as it travels from a port owner to the controller
   typedef struct packed
   {
      logic       write;                 // one cycle write strobe
      mgmt_addr_t address;               // {channel, register}
      mgmt_data_t writedata;             // payload that goes with the strobe
   } mgmt_req_t;

   // states of the user access FSM
   typedef enum logic [2:0]
   {
      IDLE                 = 3'd0,       // no user request seen
      CHECK_PHY_PRIORITY   = 3'd1,       // let pending LT/AN work go first when the PHY wins
      CHECK_PENDING_ACTION = 3'd2,       // master held off, busy window running
      WAIT_NOT_BUSY        = 3'd3,       // master still in a service, wait it out
      GRANT_USER           = 3'd4,       // user owns the port
      CHECK_RELEASE        = 3'd5        // user let go, grant held through release window
   } access_state_t;

endpackage

/* user_access_ctrl/access_wait_timer.sv */
/*
 down counter for the two windows of the user access FSM
 a start strobe loads the window length, window_done is high at zero
*/
`timescale 1ns/10ps

module access_wait_timer
#(
   parameter int BUSY_WINDOW    = 2,     // cycles to watch for a master action already under way
   parameter int RELEASE_WINDOW = 9      // cycles the grant is held after the user lets go
)
(
   input  logic clk,
   input  logic reset,
   input  logic start_busy_window,
   input  logic start_release_window,
   output logic window_done
);

   localparam int MAX_WINDOW = (BUSY_WINDOW > RELEASE_WINDOW) ? BUSY_WINDOW : RELEASE_WINDOW;
   // one spare count keeps the width at least one bit for zero length windows
   localparam int CNT_W = $clog2(MAX_WINDOW + 2);

   logic [CNT_W-1:0] count;

   assign window_done = (count == '0);   // stays high until the next strobe

   always_ff @(posedge clk)
   begin
      if (reset)
         count <= '0;
      else if (start_busy_window)
         count <= CNT_W'(BUSY_WINDOW);
      else if (start_release_window)
         count <= CNT_W'(RELEASE_WINDOW);
      else if (count != '0)
         count <= count - 1'b1;          // holds at zero once the window has run out
   end

endmodule

/* user_access_ctrl/user_access_fsm.sv */
/*
 user access FSM for the management port of the reconfiguration controller
 holds the PHY master off with force_busy, waits out the busy window,
 grants the user, then keeps the grant through the release window
 window timing comes from the separate wait timer
*/
`timescale 1ns/10ps

module user_access_fsm
#(
   parameter int USER_PRIORITY = 0       // 0 means pending LT/AN requests go ahead of the user
)
(
   input  logic clk,
   input  logic reset,
   input  logic user_request,            // level, held for as long as the user wants the port
   input  logic master_busy,             // PHY master is inside a service
   input  logic pending,                 // OR of the master's request latches
   input  logic window_done,             // timer has counted its window down
   output logic force_busy,              // keeps the master from starting a new service
   output logic grant_user,              // user owns the management port
   output logic mgmt_busy,               // busy level to the system arbiter
   output logic start_busy_window,       // loads the busy check window into the timer
   output logic start_release_window     // loads the release window into the timer
);

   rcfg_pkg::access_state_t state;

   logic phy_clear;                      // nothing from the PHY side that should go first

   // with PHY priority the user waits until every latched request has been served
   assign phy_clear = (USER_PRIORITY != 0) || !pending;

   // the strobes fire on the edge that enters the timed state, so the timer
   // already holds the loaded count in the first cycle of that state
   assign start_busy_window = (state == rcfg_pkg::CHECK_PHY_PRIORITY) && user_request &&
                              phy_clear && !master_busy;
   assign start_release_window = (state == rcfg_pkg::GRANT_USER) && !user_request;

   // arbiter sees the master's own busy while idle and a forced busy otherwise
   assign mgmt_busy = force_busy | master_busy;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state      <= rcfg_pkg::IDLE;
         force_busy <= 1'b0;
         grant_user <= 1'b0;
      end
      else
      begin
         case (state)
            rcfg_pkg::IDLE:
            begin
               force_busy <= 1'b0;
               grant_user <= 1'b0;
               if (user_request)
                  state <= rcfg_pkg::CHECK_PHY_PRIORITY;
            end

            rcfg_pkg::CHECK_PHY_PRIORITY:
            begin
               // master stays free here so that it can drain its latches
               if (!user_request)
               begin
                  state <= rcfg_pkg::IDLE;                 // user gave up before any hold
               end
               else if (phy_clear)
               begin
                  force_busy <= 1'b1;                      // from now on no new service starts
                  if (master_busy)
                     state <= rcfg_pkg::WAIT_NOT_BUSY;
                  else
                     state <= rcfg_pkg::CHECK_PENDING_ACTION;
               end
            end

            rcfg_pkg::CHECK_PENDING_ACTION:
            begin
               // a service that started on the same edge as force_busy shows up
               // on master_busy inside this window
               if (window_done)
               begin
                  if (master_busy)
                  begin
                     state <= rcfg_pkg::WAIT_NOT_BUSY;
                  end
                  else
                  begin
                     state      <= rcfg_pkg::GRANT_USER;
                     grant_user <= 1'b1;
                  end
               end
            end

            rcfg_pkg::WAIT_NOT_BUSY:
            begin
               if (!master_busy)
               begin
                  state      <= rcfg_pkg::GRANT_USER;
                  grant_user <= 1'b1;                      // master finished, port is free
               end
            end

            rcfg_pkg::GRANT_USER:
            begin
               if (!user_request)
                  state <= rcfg_pkg::CHECK_RELEASE;        // release window starts on this edge
            end

            rcfg_pkg::CHECK_RELEASE:
            begin
               // grant stays up so a late user write still reaches the controller
               if (window_done && !master_busy)
               begin
                  state      <= rcfg_pkg::IDLE;
                  grant_user <= 1'b0;
                  force_busy <= 1'b0;                      // master may resume on the next edge
               end
            end

            default:
            begin
               state      <= rcfg_pkg::IDLE;
               force_busy <= 1'b0;
               grant_user <= 1'b0;
            end
         endcase
      end
   end

endmodule

/* hdl/phy_rcfg_master.sv */
/*
 PHY reconfiguration master for link training and auto-negotiation
 sticky request latch per channel with round-robin service order
 one management write per service, then a fixed busy time
*/
`timescale 1ns/10ps

module phy_rcfg_master
#(
   parameter int CHANNELS       = 12,    // up to 16, bounded by the channel field of the address
   parameter int SERVICE_CYCLES = 6      // cycles master_busy stays high per service
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic [CHANNELS-1:0] lt_an_req,    // one cycle request pulses, one bit per channel
   input  logic                force_busy,   // user side holds the master off
   output logic                pending,      // at least one channel waits for service
   output logic                master_busy,
   output rcfg_pkg::mgmt_req_t master_req
);

   // largest count value is SERVICE_CYCLES-1
   localparam int SVC_W = (SERVICE_CYCLES > 2) ? $clog2(SERVICE_CYCLES) : 1;

   logic [CHANNELS-1:0] req_latch;
   logic [CHANNELS-1:0] clr_mask;        // latch served on this edge
   logic                start;           // a service begins on this edge
   logic [SVC_W-1:0]    svc_cnt;         // remaining busy cycles after the current one

   rcfg_pkg::chan_idx_t last_chan;       // most recently served channel
   rcfg_pkg::chan_idx_t pick;            // next channel in round-robin order

   logic                   wr_q;
   rcfg_pkg::mgmt_addr_t   addr_q;
   rcfg_pkg::mgmt_data_t   data_q;

   assign pending = |req_latch;
   assign start   = pending && !force_busy && !master_busy;

   // search starts one past the last served channel and wraps around
   always_comb
   begin
      int  idx;
      logic hit;
      idx  = 0;
      hit  = 1'b0;
      pick = '0;
      for (int i = 1; i <= CHANNELS; i++)
      begin
         idx = int'(last_chan) + i;
         if (idx >= CHANNELS)
            idx = idx - CHANNELS;
         if (!hit && req_latch[idx])
         begin
            hit  = 1'b1;
            pick = rcfg_pkg::chan_idx_t'(idx);
         end
      end
   end

   always_comb
   begin
      clr_mask = '0;
      if (start)
         clr_mask[pick] = 1'b1;
   end

   // a new pulse wins over the clear, so a request that lands during its
   // own service is kept for a later pass
   always_ff @(posedge clk)
   begin
      if (reset)
         req_latch <= '0;
      else
         req_latch <= (req_latch & ~clr_mask) | lt_an_req;
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_q        <= 1'b0;
         master_busy <= 1'b0;
         svc_cnt     <= '0;
         last_chan   <= rcfg_pkg::chan_idx_t'(CHANNELS - 1);   // channel 0 goes first
      end
      else
      begin
         wr_q <= start;                  // write strobe only in the first service cycle
         if (start)
         begin
            master_busy <= 1'b1;
            svc_cnt     <= SVC_W'(SERVICE_CYCLES - 1);
            last_chan   <= pick;
         end
         else if (master_busy)
         begin
            if (svc_cnt == '0)
               master_busy <= 1'b0;
            else
               svc_cnt <= svc_cnt - 1'b1;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         addr_q <= {pick, rcfg_pkg::LT_AN_REG};            // register of the served channel
         data_q <= rcfg_pkg::mgmt_data_t'(pick);
      end
   end

   assign master_req = '{write: wr_q, address: addr_q, writedata: data_q};

endmodule

/* hdl/mgmt_port_mux.sv */
/*
 owner mux in front of the controller's management port
 user request while granted, PHY master request otherwise
 registered output and a flag for user writes without a grant
*/
`timescale 1ns/10ps

module mgmt_port_mux
(
   input  logic                clk,
   input  logic                reset,
   input  logic                grant_user,
   input  rcfg_pkg::mgmt_req_t user_mgmt,
   input  rcfg_pkg::mgmt_req_t master_req,
   output rcfg_pkg::mgmt_req_t mgmt_out,
   output logic                user_access_error    // one cycle pulse per rejected write
);

   rcfg_pkg::mgmt_req_t sel;             // request of the current owner

   logic                 wr_q;
   rcfg_pkg::mgmt_addr_t addr_q;
   rcfg_pkg::mgmt_data_t data_q;
   logic                 err_q;

   // without a grant the user path is not selected, so its write never reaches the port
   assign sel = grant_user ? user_mgmt : master_req;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         wr_q  <= 1'b0;
         err_q <= 1'b0;
      end
      else
      begin
         wr_q  <= sel.write;
         err_q <= !grant_user && user_mgmt.write;    // write dropped, report it
      end
   end

   // address and data only move with a write, so the port holds the last request
   always_ff @(posedge clk)
   begin
      if (sel.write)
      begin
         addr_q <= sel.address;
         data_q <= sel.writedata;
      end
   end

   assign mgmt_out          = '{write: wr_q, address: addr_q, writedata: data_q};
   assign user_access_error = err_q;

endmodule

/* hdl/rcfg_access_top.sv */
/*
 top level of the management port access control
 user access FSM, its wait timer, the PHY reconfiguration master
 and the port mux, with all parameters set here
*/
`timescale 1ns/10ps

module rcfg_access_top
#(
   parameter int CHANNELS       = 12,
   parameter int USER_PRIORITY  = 0,
   parameter int BUSY_WINDOW    = 2,
   parameter int RELEASE_WINDOW = 9,
   parameter int SERVICE_CYCLES = 6
)
(
   input  logic                clk,
   input  logic                reset,
   input  logic                user_request,
   input  rcfg_pkg::mgmt_req_t user_mgmt,
   input  logic [CHANNELS-1:0] lt_an_req,
   output logic                grant_user,
   output logic                mgmt_busy,
   output logic                master_busy,
   output rcfg_pkg::mgmt_req_t mgmt_out,
   output logic                user_access_error
);

   logic                force_busy;
   logic                pending;
   logic                start_busy_window;
   logic                start_release_window;
   logic                window_done;
   rcfg_pkg::mgmt_req_t master_req;

   user_access_fsm #(.USER_PRIORITY(USER_PRIORITY)) i_user_access_fsm (
      .clk(clk), .reset(reset), .user_request(user_request),
      .master_busy(master_busy), .pending(pending), .window_done(window_done),
      .force_busy(force_busy), .grant_user(grant_user), .mgmt_busy(mgmt_busy),
      .start_busy_window(start_busy_window), .start_release_window(start_release_window)
   );

   access_wait_timer #(.BUSY_WINDOW(BUSY_WINDOW), .RELEASE_WINDOW(RELEASE_WINDOW))
   i_access_wait_timer (
      .clk(clk), .reset(reset), .start_busy_window(start_busy_window),
      .start_release_window(start_release_window), .window_done(window_done)
   );

   phy_rcfg_master #(.CHANNELS(CHANNELS), .SERVICE_CYCLES(SERVICE_CYCLES)) i_phy_rcfg_master (
      .clk(clk), .reset(reset), .lt_an_req(lt_an_req), .force_busy(force_busy),
      .pending(pending), .master_busy(master_busy), .master_req(master_req)
   );

   mgmt_port_mux i_mgmt_port_mux (
      .clk(clk), .reset(reset), .grant_user(grant_user), .user_mgmt(user_mgmt),
      .master_req(master_req), .mgmt_out(mgmt_out), .user_access_error(user_access_error)
   );

endmodule

/* verif/tb_rcfg_access.sv */
/*
 testbench for the management port access control
 random LT/AN request pulses, user grant, forwarding, ungranted writes, release
 concurrent assertions on the port rules and a monitor for the master writes
*/
`timescale 1ns/10ps

module tb_rcfg_access;

   localparam int CHANNELS       = 12;
   localparam int USER_PRIORITY  = 0;
   localparam int BUSY_WINDOW    = 2;
   localparam int RELEASE_WINDOW = 9;
   localparam int SERVICE_CYCLES = 6;

   logic                clk;
   logic                reset;
   logic                user_request;
   rcfg_pkg::mgmt_req_t user_mgmt;
   logic [CHANNELS-1:0] lt_an_req;
   logic                grant_user;
   logic                mgmt_busy;
   logic                master_busy;
   rcfg_pkg::mgmt_req_t mgmt_out;
   logic                user_access_error;

   integer              seed = 65;
   int                  check_errors = 0;
   int                  timeout_errors = 0;
   logic [CHANNELS-1:0] outstanding = '0;    // channels pulsed whose write has not shown up yet
   logic                user_phase = 1'b0;   // user_request may be up, so a grant is allowed
   logic                grant_prev = 1'b0;   // grant_user one cycle back, owner of mgmt_out
   int                  rel_cnt = 0;         // granted cycles since user_request fell
   rcfg_pkg::chan_idx_t mon_chan;
   rcfg_pkg::access_state_t fsm_state = rcfg_pkg::IDLE;

   rcfg_access_top #(.CHANNELS(CHANNELS), .USER_PRIORITY(USER_PRIORITY),
                     .BUSY_WINDOW(BUSY_WINDOW), .RELEASE_WINDOW(RELEASE_WINDOW),
                     .SERVICE_CYCLES(SERVICE_CYCLES)) i_rcfg_access_top (
      .clk(clk), .reset(reset), .user_request(user_request), .user_mgmt(user_mgmt),
      .lt_an_req(lt_an_req), .grant_user(grant_user), .mgmt_busy(mgmt_busy),
      .master_busy(master_busy), .mgmt_out(mgmt_out), .user_access_error(user_access_error)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;          // 40 ns period
   end

   always @(posedge clk)
   begin
      if (user_request)
         rel_cnt <= 0;
      else if (grant_user)
         rel_cnt <= rel_cnt + 1;          // counts the hold after the user let go
   end

   a_mutex: assert property (@(posedge clk) disable iff (reset) !(grant_user && master_busy))
      else
      begin
         $display("ERROR mutual_exclusion: expected grant_user/master_busy 0/0, actual 1/1");
         check_errors++;
      end
   a_grant_busy: assert property (@(posedge clk) disable iff (reset) grant_user |-> mgmt_busy)
      else
      begin
         $display("ERROR grant_busy: expected mgmt_busy 1, actual 0");
         check_errors++;
      end
   // a write seen while granted must be one that the user made under the grant
   a_no_master_in_grant: assert property (@(posedge clk) disable iff (reset)
      (mgmt_out.write && grant_user) |-> $past(grant_user))
      else
      begin
         $display("ERROR master_in_grant: master write reached mgmt_out during a user grant");
         check_errors++;
      end
   a_forward: assert property (@(posedge clk) disable iff (reset)
      $past(grant_user && user_mgmt.write) |-> mgmt_out == $past(user_mgmt))
      else
      begin
         $display("ERROR user_forward: expected %h, actual %h", $past(user_mgmt), mgmt_out);
         check_errors++;
      end
   a_error_pulse: assert property (@(posedge clk) disable iff (reset)
      user_access_error == $past(user_mgmt.write && !grant_user))
      else
      begin
         $display("ERROR access_error: expected %0b, actual %0b",
                  $past(user_mgmt.write && !grant_user), user_access_error);
         check_errors++;
      end
   a_no_ungranted_write: assert property (@(posedge clk) disable iff (reset)
      $past(user_mgmt.write && !grant_user && !master_busy) |-> !mgmt_out.write)
      else
      begin
         $display("ERROR ungranted_write: expected mgmt_out.write 0, actual 1");
         check_errors++;
      end
   a_no_stray_grant: assert property (@(posedge clk) disable iff (reset)
      !user_phase |-> !grant_user)
      else
      begin
         $display("ERROR stray_grant: expected grant_user 0, actual 1");
         check_errors++;
      end
   a_release_hold: assert property (@(posedge clk) disable iff (reset)
      $fell(grant_user) |-> rel_cnt >= RELEASE_WINDOW + 1)
      else
      begin
         $display("ERROR release_hold: expected at least %0d cycles, actual %0d",
                  RELEASE_WINDOW + 1, $sampled(rel_cnt));
         check_errors++;
      end

   // master writes are the ones whose owner one cycle back was the master
   always @(negedge clk)
   begin
      if (!reset && mgmt_out.write && !grant_prev)
      begin
         mon_chan = mgmt_out.address[9:6];
         assert (mgmt_out.address[5:0] == rcfg_pkg::LT_AN_REG)
         else
         begin
            $display("ERROR master_register: expected %h, actual %h",
                     rcfg_pkg::LT_AN_REG, mgmt_out.address[5:0]);
            check_errors++;
         end
         assert (mgmt_out.writedata == rcfg_pkg::mgmt_data_t'(mon_chan))
         else
         begin
            $display("ERROR master_data: expected %h, actual %h",
                     rcfg_pkg::mgmt_data_t'(mon_chan), mgmt_out.writedata);
            check_errors++;
         end
         assert (int'(mon_chan) < CHANNELS && outstanding[mon_chan])
         else
         begin
            $display("master wrote channel %0d, which had no open request", mon_chan);
            check_errors++;
         end
         if (int'(mon_chan) < CHANNELS)
            outstanding[mon_chan] = 1'b0;  // served exactly once
      end
      grant_prev = grant_user;
      if (i_rcfg_access_top.i_user_access_fsm.state != fsm_state)
      begin
         fsm_state = i_rcfg_access_top.i_user_access_fsm.state;
         $display("%0t ns  fsm state %s", $time, fsm_state.name());
      end
   end

   task automatic compare_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected)
      else
      begin
         $display("ERROR %s: expected %0b, actual %0b", name, expected, actual);
         check_errors++;
      end
   endtask

   task automatic pulse_random_channels(input int cycles);
      logic [CHANNELS-1:0] mask;
      for (int i = 0; i < cycles; i++)
      begin
         @(posedge clk);
         #2;
         mask = '0;
         if (($random(seed) & 3) == 0)
            mask = CHANNELS'($random(seed)) & ~outstanding;   // only channels with no open request
         lt_an_req   = mask;
         outstanding = outstanding | mask;
      end
      @(posedge clk);
      #2;
      lt_an_req = '0;
   endtask

   task automatic wait_master_drain(input int limit);
      int n;
      n = 0;
      while ((outstanding != '0 || master_busy || mgmt_out.write) && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (outstanding != '0 || master_busy)
      begin
         $display("PHY master did not serve channels %b within %0d cycles", outstanding, limit);
         timeout_errors++;
      end
   endtask

   task automatic wait_for_grant(input logic level, input int limit);
      int n;
      n = 0;
      while (grant_user !== level && n < limit)
      begin
         @(negedge clk);
         n++;
      end
      if (grant_user !== level)
      begin
         $display("grant_user did not go to %0b within %0d cycles", level, limit);
         timeout_errors++;
      end
   endtask

   // one cycle write strobe, started 2 ns after a rising edge
   task automatic user_write(input rcfg_pkg::mgmt_addr_t addr, input rcfg_pkg::mgmt_data_t data);
      @(posedge clk);
      #2;
      user_mgmt = '{write: 1'b1, address: addr, writedata: data};
      @(posedge clk);
      #2;
      user_mgmt.write = 1'b0;
   endtask

   initial
   begin
      reset        = 1'b1;
      user_request = 1'b0;
      user_mgmt    = '0;
      lt_an_req    = '0;
      repeat (2) @(posedge clk);
      #2;
      reset = 1'b0;
      @(negedge clk);
      compare_bit("reset_grant_user", 1'b0, grant_user);
      compare_bit("reset_master_busy", 1'b0, master_busy);
      compare_bit("reset_access_error", 1'b0, user_access_error);
      compare_bit("reset_mgmt_write", 1'b0, mgmt_out.write);
      compare_bit("reset_mgmt_busy", 1'b0, mgmt_busy);

      pulse_random_channels(60);
      wait_master_drain(600);

      // write without a grant while the master is idle, must be dropped and flagged
      user_write(rcfg_pkg::mgmt_addr_t'($random(seed)), $random(seed));
      repeat (3) @(posedge clk);

      #2;
      user_phase   = 1'b1;
      user_request = 1'b1;
      wait_for_grant(1'b1, 40);
      @(posedge clk);
      #2;
      lt_an_req   = ~outstanding;        // every channel, these wait in the latches until the release
      outstanding = '1;
      @(posedge clk);
      #2;
      lt_an_req = '0;
      for (int i = 0; i < 4; i++)
         user_write(rcfg_pkg::mgmt_addr_t'($random(seed)), $random(seed));
      @(posedge clk);
      #2;
      user_request = 1'b0;
      wait_for_grant(1'b0, RELEASE_WINDOW + SERVICE_CYCLES + 20);
      @(posedge clk);
      #2;
      user_phase = 1'b0;
      wait_master_drain(300);
      compare_bit("held_requests_served", 1'b1, outstanding == '0);
      repeat (4) @(posedge clk);

      $display("check errors: %0d, timeouts: %0d", check_errors, timeout_errors);
      if (check_errors == 0 && timeout_errors == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

/* files.f */
common/rcfg_pkg.sv
user_access_ctrl/access_wait_timer.sv
user_access_ctrl/user_access_fsm.sv
hdl/phy_rcfg_master.sv
hdl/mgmt_port_mux.sv
hdl/rcfg_access_top.sv
verif/tb_rcfg_access.sv

/* Makefile */
# Verilator build and run of the management port access testbench

TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_rcfg_access
FILE_LIST = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

# every source named in the file list, so an edit to any of them triggers a rebuild
SOURCES = $(shell grep -v '^+' $(FILE_LIST))
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILE_LIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(OBJ_DIR) -o V$(TOP)

# the run fails unless the pass message shows up as a line of its own
run: $(BIN)
	out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
